// File: include/fft_settings.svh
`ifndef FFT_SETTINGS_SVH
`define FFT_SETTINGS_SVH

// ************************************************************
// fixed-point format
// ************************************************************

`define FFT_BIT_WIDTH  32 // whole sample word.
`define FFT_DECIMAL_PT 16 // fraction bits, q16.16.

// ************************************************************
// transform geometry
// ************************************************************

`define FFT_N_SAMPLES  8 // points per transform.
`define FFT_STAGES     3 // log2 of the size.

`endif

// File: rtl/fixed_point_pkg.sv
`include "fft_settings.svh"

package fixed_point_pkg;

  // ************************************************************
  // q16.16 sample and complex word
  // ************************************************************

  typedef logic signed [`FFT_BIT_WIDTH-1:0] sample_t; // signed q16.16.

  // imaginary half sits above the real half.
  typedef struct packed {
    sample_t im;
    sample_t re;
  } complex_parts_t;

  // same 64 bits, seen either as a raw word or as re/im parts.
  typedef union packed {
    logic [2*`FFT_BIT_WIDTH-1:0] raw; // clear, load, compare.
    complex_parts_t              part; // arithmetic view.
  } complex_word_t;

endpackage

// File: rtl/fft_ctrl_pkg.sv
`include "fft_settings.svh"

package fft_ctrl_pkg;

  typedef enum logic [1:0] {
    IDLE, // waiting for a sample set.
    COMP, // one stage per cycle.
    DONE  // result held for the consumer.
  } fft_state_t;

  typedef logic [$clog2(`FFT_STAGES)-1:0] stage_t; // 0 .. stages-1.

endpackage

// File: rtl/twiddle_rom.sv
`timescale 1ns/100ps
`include "fft_settings.svh"

module twiddle_rom (
  input  logic                          clk,
  input  fft_ctrl_pkg::stage_t          stage,
  output fixed_point_pkg::complex_word_t twiddle [`FFT_N_SAMPLES/2]
);
  import fixed_point_pkg::*;
  import fft_ctrl_pkg::*;

  localparam int n_pairs = `FFT_N_SAMPLES / 2;

  // cos(q * pi/8) for q = 0..4, rounded to q16.16.
  localparam sample_t cos_table [5] = '{
    sample_t'(65536),
    sample_t'(60547),
    sample_t'(46341),
    sample_t'(25080),
    sample_t'(0)
  };

  logic [1:0] shift;
  logic [1:0] expo  [n_pairs];
  logic [2:0] angle [n_pairs]; // in steps of pi/8.

  // angle index 0..7, folded onto the quarter wave.
  function automatic sample_t cos_at(input logic [2:0] ang);
    sample_t r;
    if (ang <= 3'd4) begin
      r = cos_table[ang];
    end else begin
      r = -cos_table[3'(4'd8 - {1'b0, ang})];
    end
    return r;
  endfunction

  function automatic sample_t sin_at(input logic [2:0] ang);
    sample_t r;
    if (ang <= 3'd4) begin
      r = cos_table[3'd4 - ang];
    end else begin
      r = cos_table[ang - 3'd4];
    end
    return r;
  endfunction

  assign shift = 2'(`FFT_STAGES - 1) - stage;

  // exponent keeps the top bits of the pair index, more of them each stage.
  for (genvar k = 0; k < n_pairs; k++) begin : g_expo
    assign expo[k]  = (2'(k) >> shift) << shift;
    assign angle[k] = {expo[k], 1'b0}; // 2*pi*e/8 = e * pi/4.
  end

  always_comb begin
    for (int k = 0; k < n_pairs; k++) begin
      twiddle[k].part.re = cos_at(angle[k]);
      twiddle[k].part.im = -sin_at(angle[k]); // w = cos - j*sin.
    end
  end

  // table and exponent rule only cover the 8-point case.
  a_stage_range: assert property (
    @(posedge clk) (`FFT_N_SAMPLES == 8) && (stage <= stage_t'(`FFT_STAGES - 1))
  ) else $error("twiddle_rom: stage %0d out of range", stage);

endmodule

// File: rtl/butterfly.sv
`timescale 1ns/100ps
`include "fft_settings.svh"

module butterfly (
  input  fixed_point_pkg::complex_word_t a,
  input  fixed_point_pkg::complex_word_t b,
  input  fixed_point_pkg::complex_word_t w,
  output fixed_point_pkg::complex_word_t c,
  output fixed_point_pkg::complex_word_t d
);
  import fixed_point_pkg::*;

  localparam int prod_width = 2 * `FFT_BIT_WIDTH;

  // full-width products of twiddle and b.
  logic signed [prod_width-1:0] p_rr;
  logic signed [prod_width-1:0] p_ii;
  logic signed [prod_width-1:0] p_ri;
  logic signed [prod_width-1:0] p_ir;

  // same products back in q16.16.
  sample_t q_rr;
  sample_t q_ii;
  sample_t q_ri;
  sample_t q_ir;

  sample_t t_re;
  sample_t t_im;

  assign p_rr = w.part.re * b.part.re;
  assign p_ii = w.part.im * b.part.im;
  assign p_ri = w.part.re * b.part.im;
  assign p_ir = w.part.im * b.part.re;

  assign q_rr = sample_t'(p_rr >>> `FFT_DECIMAL_PT); // truncates toward -inf.
  assign q_ii = sample_t'(p_ii >>> `FFT_DECIMAL_PT);
  assign q_ri = sample_t'(p_ri >>> `FFT_DECIMAL_PT);
  assign q_ir = sample_t'(p_ir >>> `FFT_DECIMAL_PT);

  // t = w * b.
  assign t_re = q_rr - q_ii;
  assign t_im = q_ri + q_ir;

  always_comb begin
    c.part.re = a.part.re + t_re; // wraps, no saturation.
    c.part.im = a.part.im + t_im;
    d.part.re = a.part.re - t_re;
    d.part.im = a.part.im - t_im;
  end

endmodule

// File: rtl/fft_pease.sv
`timescale 1ns/100ps
`include "fft_settings.svh"

module fft_pease (
  input  logic                     clk,
  input  logic                     reset,
  input  fixed_point_pkg::sample_t recv_msg [`FFT_N_SAMPLES],
  input  logic                     recv_val,
  output logic                     recv_rdy,
  output fixed_point_pkg::sample_t send_msg [`FFT_N_SAMPLES],
  output logic                     send_val,
  input  logic                     send_rdy
);
  import fixed_point_pkg::*;
  import fft_ctrl_pkg::*;

  localparam int n_words = `FFT_N_SAMPLES;
  localparam int n_pairs = `FFT_N_SAMPLES / 2;

  fft_state_t state;
  fft_state_t next_state;
  stage_t     stage;
  stage_t     next_stage;
  logic       accept;

  complex_word_t regs    [n_words]; // working register.
  complex_word_t loaded  [n_words];
  complex_word_t bf_out  [n_words];
  complex_word_t perm    [n_words];
  complex_word_t twiddle [n_pairs];

  function automatic int bit_rev(input int idx);
    int r;
    r = 0;
    for (int b = 0; b < `FFT_STAGES; b++) begin
      r = (r << 1) | ((idx >> b) & 1);
    end
    return r;
  endfunction

  // ************************************************************
  // controller
  // ************************************************************

  assign recv_rdy = (state == IDLE) || (state == DONE && send_rdy);
  assign send_val = (state == DONE);
  assign accept   = recv_val && recv_rdy;

  always_comb begin
    next_state = state;
    next_stage = stage;
    unique case (state)
      IDLE: begin
        if (accept) begin
          next_state = COMP;
        end
      end
      COMP: begin
        if (stage == stage_t'(`FFT_STAGES - 1)) begin
          next_state = DONE;
          next_stage = '0;
        end else begin
          next_stage = stage + 1'b1;
        end
      end
      DONE: begin
        if (send_rdy) begin
          next_state = accept ? COMP : IDLE; // take and reload on one edge.
        end
      end
      default: begin
        next_state = IDLE;
        next_stage = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      stage <= '0;
    end else begin
      state <= next_state;
      stage <= next_stage;
    end
  end

  // ************************************************************
  // data path
  // ************************************************************

  always_comb begin
    for (int i = 0; i < n_words; i++) begin
      loaded[i].part.re = recv_msg[bit_rev(i)]; // bit-reversed, real only.
      loaded[i].part.im = '0;
    end
  end

  twiddle_rom i_twiddle (
    .clk    (clk),
    .stage  (stage),
    .twiddle(twiddle)
  );

  for (genvar k = 0; k < n_pairs; k++) begin : g_bf
    butterfly i_butterfly (
      .a(regs[2*k]),
      .b(regs[2*k+1]),
      .w(twiddle[k]),
      .c(bf_out[2*k]),
      .d(bf_out[2*k+1])
    );
  end

  // perfect shuffle, j -> (j mod 2)*n/2 + j/2.
  always_comb begin
    for (int j = 0; j < n_words; j++) begin
      perm[(j % 2) * n_pairs + j / 2] = bf_out[j];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < n_words; i++) begin
        regs[i].raw <= '0;
      end
    end else if (accept) begin
      regs <= loaded;
    end else if (state == COMP) begin
      regs <= perm;
    end
  end

  always_comb begin
    for (int i = 0; i < n_words; i++) begin
      send_msg[i] = regs[i].part.re;
    end
  end

  // ************************************************************
  // checks
  // ************************************************************

  a_send_val_held: assert property (
    @(posedge clk) disable iff (reset) (send_val && !send_rdy) |=> send_val
  ) else $error("fft_pease: send_val dropped before the result was taken");

  for (genvar i = 0; i < n_words; i++) begin : g_hold
    a_regs_held: assert property (
      @(posedge clk) disable iff (reset)
      (state == DONE && !send_rdy) |=> $stable(regs[i].raw)
    ) else $error("fft_pease: word %0d changed under back-pressure", i);
  end

endmodule

// File: tb/tb_fft_pease.sv
`timescale 1ns/100ps
`include "fft_settings.svh"

module tb_fft_pease;
  import fixed_point_pkg::*;

  localparam int n_pts          = `FFT_N_SAMPLES;
  localparam int n_stages       = `FFT_STAGES;
  localparam int n_sets         = 24;
  localparam int bb_start       = 16; // sets from here on run back to back.
  localparam int half_period    = 4;
  localparam int timeout_cycles = n_sets * 20 + 100;
  localparam int dft_tol        = 64; // 2^-10 in q16.16 steps.
  localparam real pi            = 3.14159265358979;

  logic    clk;
  logic    reset;
  sample_t recv_msg [n_pts];
  logic    recv_val;
  logic    recv_rdy;
  sample_t send_msg [n_pts];
  logic    send_val;
  logic    send_rdy;

  integer  seed;
  sample_t set_mem   [n_sets][n_pts];
  sample_t known_mem [n_sets][n_pts]; // closed-form answers for the first three sets.
  logic    has_known [n_sets];
  sample_t acc_mem   [n_sets][n_pts];
  int      acc_cnt  = 0;
  int      take_cnt = 0;
  int      cyc      = 0;
  int      acc_cyc  = 0;
  logic    val_q;
  logic    hold_q;
  sample_t prev_msg [n_pts];
  sample_t model_in [n_pts];
  sample_t want     [n_pts];

  fft_pease i_dut (
    .clk     (clk),
    .reset   (reset),
    .recv_msg(recv_msg),
    .recv_val(recv_val),
    .recv_rdy(recv_rdy),
    .send_msg(send_msg),
    .send_val(send_val),
    .send_rdy(send_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // ************************************************************
  // reporting and reference model
  // ************************************************************

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input int expected, input int actual,
                             input int tol);
    int diff;
    diff = expected - actual;
    if (diff < 0) begin
      diff = -diff;
    end
    if (diff > tol) begin
      abort_run($sformatf("ERR %0t %s expected %0d got %0d", $time, name, expected, actual));
    end
  endtask

  function automatic int round_raw(input real r);
    return (r >= 0.0) ? $rtoi(r + 0.5) : -$rtoi(-r + 0.5);
  endfunction

  function automatic int rev_index(input int idx);
    int r;
    r = 0;
    for (int b = 0; b < n_stages; b++) begin
      if (((idx >> b) & 1) != 0) begin
        r = r | (1 << (n_stages - 1 - b));
      end
    end
    return r;
  endfunction

  function automatic sample_t fix_mul(input sample_t a, input sample_t b);
    longint p;
    p = longint'(a) * longint'(b);
    return sample_t'(p >>> `FFT_DECIMAL_PT); // floor, then keep 32 bits.
  endfunction

  function automatic void model_fft(input sample_t x [n_pts], output sample_t y [n_pts]);
    sample_t re  [n_pts];
    sample_t im  [n_pts];
    sample_t nre [n_pts];
    sample_t nim [n_pts];
    sample_t wr;
    sample_t wi;
    sample_t tr;
    sample_t ti;
    int      e;
    int      sh;
    for (int i = 0; i < n_pts; i++) begin
      re[i] = x[rev_index(i)];
      im[i] = '0;
    end
    for (int s = 0; s < n_stages; s++) begin
      sh = n_stages - 1 - s;
      for (int k = 0; k < n_pts / 2; k++) begin
        e  = (k >> sh) << sh;
        wr = round_raw(65536.0 * $cos(2.0 * pi * e / n_pts));
        wi = -round_raw(65536.0 * $sin(2.0 * pi * e / n_pts));
        tr = fix_mul(wr, re[2*k+1]) - fix_mul(wi, im[2*k+1]);
        ti = fix_mul(wr, im[2*k+1]) + fix_mul(wi, re[2*k+1]);
        nre[k] = re[2*k] + tr; // even element lands in the low half.
        nim[k] = im[2*k] + ti;
        nre[n_pts/2 + k] = re[2*k] - tr;
        nim[n_pts/2 + k] = im[2*k] - ti;
      end
      re = nre;
      im = nim;
    end
    y = re;
  endfunction

  function automatic int dft_real(input sample_t x [n_pts], input int k);
    real acc;
    acc = 0.0;
    for (int n = 0; n < n_pts; n++) begin
      acc = acc + real'(x[n]) * $cos(2.0 * pi * k * n / n_pts);
    end
    return round_raw(acc);
  endfunction

  // ************************************************************
  // stimulus
  // ************************************************************

  initial begin
    int next_set;
    int stretch;
    seed     = 55930;
    reset    = 1'b1;
    recv_val = 1'b0;
    send_rdy = 1'b0;
    for (int i = 0; i < n_pts; i++) begin
      recv_msg[i] = '0;
    end
    for (int s = 0; s < n_sets; s++) begin
      has_known[s] = (s < 3);
      for (int i = 0; i < n_pts; i++) begin
        set_mem[s][i] = $random(seed) % 32'sd1048576; // within +-2^20.
      end
    end
    for (int i = 0; i < n_pts; i++) begin
      set_mem[0][i]   = (i == 0) ? sample_t'(65536) : sample_t'(0); // unit impulse.
      known_mem[0][i] = sample_t'(65536);
      set_mem[1][i]   = sample_t'(65536);
      known_mem[1][i] = (i == 0) ? sample_t'(524288) : sample_t'(0);
      set_mem[2][i]   = -sample_t'(212992); // -3.25.
      known_mem[2][i] = (i == 0) ? -sample_t'(1703936) : sample_t'(0);
    end

    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_value("send_val", 0, int'(send_val), 0);
    check_value("recv_rdy", 1, int'(recv_rdy), 0);

    next_set = 0;
    stretch  = 0;
    while (next_set < n_sets) begin
      for (int i = 0; i < n_pts; i++) begin
        recv_msg[i] <= set_mem[next_set][i];
      end
      if (next_set < bb_start) begin
        if (stretch == 0) begin
          send_rdy <= ($random(seed) & 1) != 0;
          stretch = 1 + ($unsigned($random(seed)) % 6);
        end
        stretch = stretch - 1;
        recv_val <= ($random(seed) & 3) != 0; // idle a quarter of the time.
      end else begin
        send_rdy <= 1'b1;
        recv_val <= 1'b1;
      end
      @(posedge clk);
      if (recv_val && recv_rdy) begin
        next_set = next_set + 1;
      end
    end
    recv_val <= 1'b0;
    send_rdy <= 1'b1;

    while (take_cnt < n_sets) @(posedge clk);
    repeat (4) @(posedge clk);
    check_value("send_val", 0, int'(send_val), 0);
    $display("Simulation passed");
    $finish;
  end

  // ************************************************************
  // response checks
  // ************************************************************

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (reset) begin
      val_q  = 1'b0;
      hold_q = 1'b0;
    end else begin
      if (send_val && !val_q) begin
        check_value("send_val latency", 3, cyc - 1 - acc_cyc, 0); // rose after edge acc+3.
      end
      if (hold_q) begin
        check_value("send_val", 1, int'(send_val), 0);
        for (int i = 0; i < n_pts; i++) begin
          check_value($sformatf("send_msg[%0d]", i), prev_msg[i], send_msg[i], 0);
        end
      end
      if (send_val && !send_rdy) begin
        check_value("recv_rdy", 0, int'(recv_rdy), 0);
      end
      if (send_val && send_rdy) begin
        check_value("recv_rdy", 1, int'(recv_rdy), 0); // a take can reload on the same edge.
        if (take_cnt >= acc_cnt) begin
          abort_run("a result was delivered with no sample set outstanding");
        end
        for (int i = 0; i < n_pts; i++) begin
          model_in[i] = acc_mem[take_cnt][i];
        end
        model_fft(model_in, want);
        for (int i = 0; i < n_pts; i++) begin
          check_value($sformatf("send_msg[%0d]", i), want[i], send_msg[i], 0);
          if (has_known[take_cnt]) begin
            check_value($sformatf("send_msg[%0d]", i), known_mem[take_cnt][i], send_msg[i], 0);
          end
          check_value($sformatf("send_msg[%0d] vs dft", i), dft_real(model_in, i),
                      send_msg[i], dft_tol);
        end
        take_cnt = take_cnt + 1;
      end
      if (recv_val && recv_rdy) begin
        for (int i = 0; i < n_pts; i++) begin
          acc_mem[acc_cnt][i] = recv_msg[i];
        end
        acc_cyc = cyc;
        acc_cnt = acc_cnt + 1;
      end
      val_q  = send_val;
      hold_q = send_val && !send_rdy;
      for (int i = 0; i < n_pts; i++) begin
        prev_msg[i] = send_msg[i];
      end
    end
  end

  initial begin
    #(timeout_cycles * 2 * half_period);
    abort_run($sformatf("timeout: the run did not finish within %0d cycles", timeout_cycles));
  end

endmodule

// File: filelist.f
+incdir+include
rtl/fixed_point_pkg.sv
rtl/fft_ctrl_pkg.sv
rtl/twiddle_rom.sv
rtl/butterfly.sv
rtl/fft_pease.sv
tb/tb_fft_pease.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the FFT testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module tb_fft_pease \
  -o sim_fft
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output="$(./obj_dir/sim_fft 2>&1)"
run_status=$?
echo "$output"

if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1
